//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	// Datapath widths
	localparam int dataW = 32;
	localparam int regAddrW = 5;

	// ------------------------------
	// Instruction field positions
	// ------------------------------
	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	// Opcode and funct share one width
	localparam int fieldW = 6;
	localparam int immW = 16;

	// Primary opcodes
	typedef enum logic [fieldW-1:0] {
		rType = 6'h00,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b,
		opHalt = 6'h3f
	} opcodeT;

	// Funct codes of R-type words
	typedef enum logic [fieldW-1:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// Execute stage operation
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

endpackage

`default_nettype wire

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;

	// Operand source in execute
	typedef enum logic [1:0] {fwdNone = 2'd0, fwdMem = 2'd1, fwdWb = 2'd2} fwdSelT;

	// ------------------------------
	// Control word and stage registers
	// ------------------------------
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic branch;
		logic halt;
		isaPkg::aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [isaPkg::dataW-1:0] instr;
		logic [isaPkg::dataW-1:0] pcPlus1;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [isaPkg::dataW-1:0] rdA;
		logic [isaPkg::dataW-1:0] rdB;
		logic [isaPkg::regAddrW-1:0] rs;
		logic [isaPkg::regAddrW-1:0] rt;
		logic [isaPkg::regAddrW-1:0] rd;
		logic [isaPkg::dataW-1:0] imm;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic halt;
		logic [isaPkg::dataW-1:0] aluOut;
		logic [isaPkg::dataW-1:0] writeData;
		logic [isaPkg::regAddrW-1:0] writeReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic halt;
		logic [isaPkg::dataW-1:0] readData;
		logic [isaPkg::dataW-1:0] aluOut;
		logic [isaPkg::regAddrW-1:0] writeReg;
	} memWbT;

	// APB register map
	localparam int apbAddrW = 12;
	localparam int regionLsb = 10;
	localparam int regionW = 2;
	// Word index starts above the byte offset
	localparam int wordLsb = 2;
	localparam logic [regionW-1:0] regionImem = 2'd0;
	localparam logic [regionW-1:0] regionRegs = 2'd1;
	localparam logic [regionW-1:0] regionCtrl = 2'd2;
	// Control register bits
	localparam int ctrlStartBit = 0;
	localparam int ctrlRunningBit = 0;
	localparam int ctrlHaltedBit = 1;

endpackage

`default_nettype wire

//--- hdl/hazardIf.sv
`timescale 1ns/1ns
`default_nettype none

interface hazardIf (
	input wire clk,
	input wire rstN
);

	// Register numbers and controls from the datapath
	logic [isaPkg::regAddrW-1:0] rsD;
	logic [isaPkg::regAddrW-1:0] rtD;
	logic branchD;
	logic [isaPkg::regAddrW-1:0] rsE;
	logic [isaPkg::regAddrW-1:0] rtE;
	logic [isaPkg::regAddrW-1:0] writeRegE;
	logic regWriteE;
	logic memToRegE;
	logic [isaPkg::regAddrW-1:0] writeRegM;
	logic regWriteM;
	logic memToRegM;
	logic [isaPkg::regAddrW-1:0] writeRegW;
	logic regWriteW;

	// Decisions back to the datapath
	logic stallF;
	logic stallD;
	logic flushE;
	logic forwardAD;
	logic forwardBD;
	pipePkg::fwdSelT forwardAE;
	pipePkg::fwdSelT forwardBE;

	modport core (
		output rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
		output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		input stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

	modport hazard (
		input clk, rstN,
		input rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
		input writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

endinterface

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input wire [isaPkg::fieldW-1:0] opcode,
	input wire [isaPkg::fieldW-1:0] funct,
	output pipePkg::ctrlT ctrl
);

	always_comb
	begin
		// Bubble unless the opcode is known
		ctrl = '0;
		ctrl.aluOp = isaPkg::aluAdd;
		case (opcode)
			isaPkg::rType:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					isaPkg::fnAdd: ctrl.aluOp = isaPkg::aluAdd;
					isaPkg::fnSub: ctrl.aluOp = isaPkg::aluSub;
					isaPkg::fnAnd: ctrl.aluOp = isaPkg::aluAnd;
					isaPkg::fnOr: ctrl.aluOp = isaPkg::aluOr;
					isaPkg::fnSlt: ctrl.aluOp = isaPkg::aluSlt;
					// Unknown funct writes nothing
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			isaPkg::opAddi:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			isaPkg::opLw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			isaPkg::opSw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			// Compare happens in decode
			isaPkg::opBeq: ctrl.branch = 1'b1;
			// End of program marker
			isaPkg::opHalt: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input wire clk,
	input wire rstN,
	input wire [isaPkg::regAddrW-1:0] raddrA,
	input wire [isaPkg::regAddrW-1:0] raddrB,
	output logic [isaPkg::dataW-1:0] rdataA,
	output logic [isaPkg::dataW-1:0] rdataB,
	input wire [isaPkg::regAddrW-1:0] waddr,
	input wire [isaPkg::dataW-1:0] wdata,
	input wire we,
	input wire [isaPkg::regAddrW-1:0] dbgAddr,
	output logic [isaPkg::dataW-1:0] dbgData
);

	logic [isaPkg::dataW-1:0] regs [32];

	// Zero register, then write bypass, then array
	function automatic logic [isaPkg::dataW-1:0] readPort(
		input logic [isaPkg::regAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		if (we && waddr == addr)
			return wdata;
		return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			regs <= '{default: '0};
		else if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdataA = readPort(raddrA);
	assign rdataB = readPort(raddrB);
	// Debug view of settled contents
	assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	hazardIf.hazard hz
);

	logic lwStall;
	logic branchStall;

	// Memory stage wins over writeback, r0 never forwarded
	function automatic pipePkg::fwdSelT fwdFor(
		input logic [isaPkg::regAddrW-1:0] src,
		input logic [isaPkg::regAddrW-1:0] regM,
		input logic weM,
		input logic [isaPkg::regAddrW-1:0] regW,
		input logic weW);
		if (src != '0 && weM && src == regM)
			return pipePkg::fwdMem;
		if (src != '0 && weW && src == regW)
			return pipePkg::fwdWb;
		return pipePkg::fwdNone;
	endfunction

	// ------------------------------
	// Forwarding
	// ------------------------------
	assign hz.forwardAE = fwdFor(hz.rsE, hz.writeRegM, hz.regWriteM, hz.writeRegW, hz.regWriteW);
	assign hz.forwardBE = fwdFor(hz.rtE, hz.writeRegM, hz.regWriteM, hz.writeRegW, hz.regWriteW);

	// Branch compare takes the memory stage ALU result
	assign hz.forwardAD = hz.rsD != '0 && hz.regWriteM && hz.rsD == hz.writeRegM;
	assign hz.forwardBD = hz.rtD != '0 && hz.regWriteM && hz.rtD == hz.writeRegM;

	// ------------------------------
	// Stalls
	// ------------------------------
	// Load result not ready for the next instruction
	assign lwStall = hz.memToRegE && (hz.rtE == hz.rsD || hz.rtE == hz.rtD);

	// Branch operand still in execute, or a load in memory
	assign branchStall = hz.branchD &&
		((hz.regWriteE && (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD)) ||
		(hz.memToRegM && (hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD)));

	assign hz.stallF = lwStall || branchStall;
	assign hz.stallD = lwStall || branchStall;
	assign hz.flushE = lwStall || branchStall;

	// Stalled decode leaves a bubble in execute
	assert property (@(posedge hz.clk) disable iff (!hz.rstN)
		hz.stallD |=> !hz.regWriteE && !hz.memToRegE);

endmodule

`default_nettype wire

//--- hdl/instrMem.sv
`timescale 1ns/1ns
`default_nettype none

module instrMem #(
	parameter int imemDepth = 256
) (
	input wire clk,
	input wire imemWe,
	input wire [$clog2(imemDepth)-1:0] imemAddr,
	input wire [isaPkg::dataW-1:0] imemData,
	input wire [$clog2(imemDepth)-1:0] fetchAddr,
	output logic [isaPkg::dataW-1:0] fetchInstr
);

	logic [isaPkg::dataW-1:0] mem [imemDepth];

	// Loaded from the debug port between runs
	always_ff @(posedge clk)
	begin
		if (imemWe)
			mem[imemAddr] <= imemData;
	end

	// Fetch reads in the same cycle
	assign fetchInstr = mem[fetchAddr];

	// Debug port index must land inside the array
	assert property (@(posedge clk) imemWe |-> imemAddr < imemDepth);

endmodule

`default_nettype wire

//--- hdl/apbDebugPort.sv
`timescale 1ns/1ns
`default_nettype none

module apbDebugPort #(
	parameter int imemDepth = 256
) (
	input wire clk,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [pipePkg::apbAddrW-1:0] paddr,
	input wire [isaPkg::dataW-1:0] pwdata,
	output logic [isaPkg::dataW-1:0] prdata,
	output logic pready,
	output logic imemWe,
	output logic [$clog2(imemDepth)-1:0] imemAddr,
	output logic [isaPkg::dataW-1:0] imemData,
	output logic [isaPkg::regAddrW-1:0] dbgRegAddr,
	input wire [isaPkg::dataW-1:0] dbgRegData,
	output logic start,
	output logic running,
	input wire haltSeen,
	output logic halted
);

	logic [pipePkg::regionW-1:0] region;
	logic wrAccess;
	logic startReq;

	// ------------------------------
	// Access decode
	// ------------------------------
	assign region = paddr[pipePkg::regionLsb +: pipePkg::regionW];
	// No wait states
	assign pready = 1'b1;
	assign wrAccess = psel && penable && pwrite;
	// Start only counts while idle
	assign startReq = wrAccess && region == pipePkg::regionCtrl &&
		pwdata[pipePkg::ctrlStartBit] && !running;

	// Program loads are dropped during a run
	assign imemWe = wrAccess && region == pipePkg::regionImem && !running;
	assign imemAddr = paddr[pipePkg::wordLsb +: $clog2(imemDepth)];
	assign imemData = pwdata;
	assign dbgRegAddr = paddr[pipePkg::wordLsb +: isaPkg::regAddrW];

	// Read mux by region
	always_comb
	begin
		prdata = '0;
		case (region)
			pipePkg::regionRegs: prdata = dbgRegData;
			pipePkg::regionCtrl:
			begin
				prdata[pipePkg::ctrlRunningBit] = running;
				prdata[pipePkg::ctrlHaltedBit] = halted;
			end
			default: prdata = '0;
		endcase
	end

	// ------------------------------
	// Run state
	// ------------------------------
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			start <= 1'b0;
			running <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			// One cycle pulse into the core
			start <= startReq;
			if (startReq)
			begin
				running <= 1'b1;
				halted <= 1'b0;
			end
			else if (haltSeen)
			begin
				running <= 1'b0;
				halted <= 1'b1;
			end
		end
	end

	// Access phase always comes out of a selected setup
	assert property (@(posedge clk) disable iff (!rstN) $rose(penable) |-> psel);

endmodule

`default_nettype wire

//--- hdl/pipeCore.sv
`timescale 1ns/1ns
`default_nettype none

module pipeCore #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 64
) (
	input wire clk,
	input wire rstN,
	input wire running,
	input wire start,
	output logic [$clog2(imemDepth)-1:0] fetchAddr,
	input wire [isaPkg::dataW-1:0] fetchInstr,
	input wire [isaPkg::regAddrW-1:0] dbgRegAddr,
	output logic [isaPkg::dataW-1:0] dbgRegData,
	output logic haltSeen
);

	localparam int dataW = isaPkg::dataW;
	localparam int immW = isaPkg::immW;

	hazardIf hz (.clk(clk), .rstN(rstN));

	logic [dataW-1:0] pcF;
	pipePkg::ifIdT ifId;
	pipePkg::idExT idEx;
	pipePkg::exMemT exMem;
	pipePkg::memWbT memWb;
	logic advance;
	logic clearAll;
	pipePkg::ctrlT ctrlD;
	logic [dataW-1:0] rdAD;
	logic [dataW-1:0] rdBD;
	logic [dataW-1:0] immD;
	logic [dataW-1:0] targetD;
	logic takenD;
	logic [dataW-1:0] srcAE;
	logic [dataW-1:0] srcBE;
	logic [dataW-1:0] writeDataE;
	logic [dataW-1:0] aluOutE;
	logic [isaPkg::regAddrW-1:0] writeRegE;
	logic [dataW-1:0] dmem [dmemDepth];
	logic [dataW-1:0] resultW;

	function automatic logic [dataW-1:0] fwdPick(input pipePkg::fwdSelT sel,
		input logic [dataW-1:0] fromReg);
		case (sel)
			pipePkg::fwdMem: return exMem.aluOut;
			pipePkg::fwdWb: return resultW;
			default: return fromReg;
		endcase
	endfunction

	// Halt in writeback freezes everything for its last cycle
	assign advance = running && !memWb.halt;
	assign haltSeen = running && memWb.halt;
	assign clearAll = start || !running;

	// ------------------------------
	// Fetch
	// ------------------------------
	assign fetchAddr = pcF[$clog2(imemDepth)-1:0];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN || clearAll)
		begin
			pcF <= '0;
			ifId <= '0;
		end
		else if (advance && !hz.stallF)
		begin
			pcF <= takenD ? targetD : pcF + 1'b1;
			// Taken branch squashes the word behind it
			ifId <= takenD ? '0 : '{instr: fetchInstr, pcPlus1: pcF + 1'b1};
		end
	end

	// ------------------------------
	// Decode
	// ------------------------------
	assign hz.rsD = ifId.instr[isaPkg::rsLsb +: isaPkg::regAddrW];
	assign hz.rtD = ifId.instr[isaPkg::rtLsb +: isaPkg::regAddrW];
	assign hz.branchD = ctrlD.branch;

	controlUnit uCtrl (
		.opcode(ifId.instr[isaPkg::opLsb +: isaPkg::fieldW]),
		.funct(ifId.instr[isaPkg::fieldW-1:0]),
		.ctrl(ctrlD)
	);

	regFile uRegs (
		.clk(clk), .rstN(rstN),
		.raddrA(hz.rsD), .raddrB(hz.rtD), .rdataA(rdAD), .rdataB(rdBD),
		.waddr(memWb.writeReg), .wdata(resultW), .we(memWb.regWrite),
		.dbgAddr(dbgRegAddr), .dbgData(dbgRegData)
	);

	hazardUnit uHazard (.hz(hz));

	assign immD = {{(dataW-immW){ifId.instr[immW-1]}}, ifId.instr[immW-1:0]};
	// Word offset from the next PC
	assign targetD = ifId.pcPlus1 + immD;
	assign takenD = ctrlD.branch && !hz.stallD &&
		((hz.forwardAD ? exMem.aluOut : rdAD) == (hz.forwardBD ? exMem.aluOut : rdBD));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN || clearAll || hz.flushE)
			idEx <= '0;
		else if (advance)
			idEx <= '{ctrl: ctrlD, rdA: rdAD, rdB: rdBD, rs: hz.rsD, rt: hz.rtD,
				rd: ifId.instr[isaPkg::rdLsb +: isaPkg::regAddrW], imm: immD};
	end

	// ------------------------------
	// Execute
	// ------------------------------
	assign hz.rsE = idEx.rs;
	assign hz.rtE = idEx.rt;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = idEx.ctrl.regWrite;
	assign hz.memToRegE = idEx.ctrl.memToReg;
	assign writeRegE = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
	assign srcAE = fwdPick(hz.forwardAE, idEx.rdA);
	assign writeDataE = fwdPick(hz.forwardBE, idEx.rdB);
	assign srcBE = idEx.ctrl.aluSrc ? idEx.imm : writeDataE;

	always_comb
	begin
		case (idEx.ctrl.aluOp)
			isaPkg::aluSub: aluOutE = srcAE - srcBE;
			isaPkg::aluAnd: aluOutE = srcAE & srcBE;
			isaPkg::aluOr: aluOutE = srcAE | srcBE;
			isaPkg::aluSlt: aluOutE = {{(dataW-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN || clearAll)
			exMem <= '0;
		else if (advance)
			exMem <= '{regWrite: idEx.ctrl.regWrite, memToReg: idEx.ctrl.memToReg,
				memWrite: idEx.ctrl.memWrite, halt: idEx.ctrl.halt, aluOut: aluOutE,
				writeData: writeDataE, writeReg: writeRegE};
	end

	// ------------------------------
	// Memory and writeback
	// ------------------------------
	assign hz.writeRegM = exMem.writeReg;
	assign hz.regWriteM = exMem.regWrite;
	assign hz.memToRegM = exMem.memToReg;

	// Byte address, whole words only
	always_ff @(posedge clk)
	begin
		if (advance && exMem.memWrite)
			dmem[exMem.aluOut[2 +: $clog2(dmemDepth)]] <= exMem.writeData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN || clearAll)
			memWb <= '0;
		else if (advance)
			memWb <= '{regWrite: exMem.regWrite, memToReg: exMem.memToReg, halt: exMem.halt,
				readData: dmem[exMem.aluOut[2 +: $clog2(dmemDepth)]],
				aluOut: exMem.aluOut, writeReg: exMem.writeReg};
	end

	assign resultW = memWb.memToReg ? memWb.readData : memWb.aluOut;
	assign hz.writeRegW = memWb.writeReg;
	assign hz.regWriteW = memWb.regWrite;

	// A taken branch lands on its target, never held by a fetch stall
	assert property (@(posedge clk) disable iff (!rstN)
		advance && takenD && !start |=> pcF == $past(targetD));

endmodule

`default_nettype wire

//--- hdl/mipsPipeTop.sv
`timescale 1ns/1ns
`default_nettype none

module mipsPipeTop #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 64
) (
	input wire clk,
	input wire rstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [pipePkg::apbAddrW-1:0] paddr,
	input wire [isaPkg::dataW-1:0] pwdata,
	output logic [isaPkg::dataW-1:0] prdata,
	output logic pready,
	output logic halted
);

	// Program load path
	logic imemWe;
	logic [$clog2(imemDepth)-1:0] imemAddr;
	logic [isaPkg::dataW-1:0] imemData;
	logic [$clog2(imemDepth)-1:0] fetchAddr;
	logic [isaPkg::dataW-1:0] fetchInstr;

	// Debug and run control
	logic [isaPkg::regAddrW-1:0] dbgRegAddr;
	logic [isaPkg::dataW-1:0] dbgRegData;
	logic start;
	logic running;
	logic haltSeen;

	apbDebugPort #(.imemDepth(imemDepth)) uDebug (
		.clk(clk), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData),
		.start(start), .running(running), .haltSeen(haltSeen), .halted(halted)
	);

	instrMem #(.imemDepth(imemDepth)) uImem (
		.clk(clk),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.fetchAddr(fetchAddr), .fetchInstr(fetchInstr)
	);

	pipeCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) uCore (
		.clk(clk), .rstN(rstN), .running(running), .start(start),
		.fetchAddr(fetchAddr), .fetchInstr(fetchInstr),
		.dbgRegAddr(dbgRegAddr), .dbgRegData(dbgRegData), .haltSeen(haltSeen)
	);

endmodule

`default_nettype wire

//--- sim/tbMipsPipe.sv
`timescale 1ns/1ns
`default_nettype none

module tbMipsPipe;

	localparam int progLen = 22;
	localparam int expCount = 18;
	// Whole run, load and both passes included
	localparam int timeoutCycles = 20 * progLen + 200;
	localparam logic [pipePkg::apbAddrW-1:0] ctrlAddr = {pipePkg::regionCtrl, 10'd0};

	typedef struct packed {
		logic [4:0] regNum;
		logic [31:0] value;
	} regExpT;

	// Register contents once halt retires
	localparam regExpT expTable [expCount] = '{
		'{5'd0, 32'd0},
		'{5'd1, 32'd5},
		'{5'd2, 32'd14},
		'{5'd3, 32'd19},
		'{5'd4, 32'd14},
		'{5'd5, 32'd2},
		'{5'd6, 32'd7},
		'{5'd7, 32'd1},
		'{5'd8, 32'hffff_fffd},
		'{5'd9, 32'd1},
		'{5'd10, 32'd100},
		'{5'd11, 32'd100},
		'{5'd12, 32'd105},
		'{5'd13, 32'd7},
		'{5'd14, 32'd19},
		// Only written by words the taken branch skips
		'{5'd15, 32'd0},
		'{5'd16, 32'd0},
		'{5'd17, 32'd14}
	};

	logic clk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [pipePkg::apbAddrW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic halted;
	logic [31:0] progWords [progLen];
	logic [31:0] rdata;
	int cycleCount = 0;

	mipsPipeTop i_dut (
		.clk(clk), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .halted(halted)
	);

	always #4 clk = ~clk;

	// ------------------------------
	// Instruction encoding
	// ------------------------------
	function automatic logic [31:0] rWord(isaPkg::functT fn, int rd, int rs, int rt);
		return {isaPkg::rType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] iWord(isaPkg::opcodeT op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [pipePkg::apbAddrW-1:0] imemAddrOf(int idx);
		return {pipePkg::regionImem, idx[7:0], 2'b00};
	endfunction

	function automatic logic [pipePkg::apbAddrW-1:0] regAddrOf(int r);
		return {pipePkg::regionRegs, 3'b000, r[4:0], 2'b00};
	endfunction

	task automatic fillProgram();
		// Dependent ALU chain, forwarding from both later stages
		progWords[0] = iWord(isaPkg::opAddi, 1, 0, 5);
		progWords[1] = iWord(isaPkg::opAddi, 2, 0, 14);
		progWords[2] = rWord(isaPkg::fnAdd, 3, 1, 2);
		progWords[3] = rWord(isaPkg::fnSub, 4, 3, 1);
		progWords[4] = rWord(isaPkg::fnAnd, 5, 4, 3);
		progWords[5] = rWord(isaPkg::fnOr, 6, 5, 1);
		progWords[6] = rWord(isaPkg::fnSlt, 7, 6, 4);
		// Signed compare with a negative operand
		progWords[7] = iWord(isaPkg::opAddi, 8, 0, -3);
		progWords[8] = rWord(isaPkg::fnSlt, 9, 8, 7);
		// Store then load back, add right behind the load
		progWords[9] = iWord(isaPkg::opAddi, 10, 0, 100);
		progWords[10] = iWord(isaPkg::opSw, 10, 0, 8);
		progWords[11] = iWord(isaPkg::opLw, 11, 0, 8);
		progWords[12] = rWord(isaPkg::fnAdd, 12, 11, 1);
		// 105 vs 19, falls through
		progWords[13] = iWord(isaPkg::opBeq, 3, 12, 1);
		progWords[14] = iWord(isaPkg::opAddi, 13, 0, 7);
		progWords[15] = iWord(isaPkg::opAddi, 14, 13, 12);
		// 19 vs 19, jumps over two words
		progWords[16] = iWord(isaPkg::opBeq, 3, 14, 2);
		progWords[17] = iWord(isaPkg::opAddi, 15, 0, 1);
		progWords[18] = iWord(isaPkg::opAddi, 16, 0, 1);
		// r0 stays zero, also as a forward source
		progWords[19] = iWord(isaPkg::opAddi, 0, 0, 9);
		progWords[20] = rWord(isaPkg::fnAdd, 17, 0, 2);
		progWords[21] = {isaPkg::opHalt, 26'd0};
	endtask

	// ------------------------------
	// APB master side
	// ------------------------------
	task automatic apbWrite(input logic [pipePkg::apbAddrW-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		// Write lands on this edge
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input logic [pipePkg::apbAddrW-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		// Mid access phase, prdata settled
		@(negedge clk);
		data = prdata;
		checkValue("pready", {31'd0, pready}, 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic waitForHalt();
		@(negedge clk);
		while (!halted)
			@(negedge clk);
	endtask

	task automatic checkRegisters();
		logic [31:0] value;
		for (int i = 0; i < expCount; i++)
		begin
			apbRead(regAddrOf(expTable[i].regNum), value);
			checkValue($sformatf("register r%0d", expTable[i].regNum), value,
				expTable[i].value);
		end
	endtask

	// Bound on the whole run
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout after %0d cycles, the program never halted", cycleCount);
			$display("Test FAILED");
			$fatal(1, "run did not finish");
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		fillProgram();
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < progLen; i++)
			apbWrite(imemAddrOf(i), progWords[i]);
		// Idle before the first start
		apbRead(ctrlAddr, rdata);
		checkValue("status before start", rdata, 32'h0);
		// Second pass reruns from PC 0
		for (int run = 0; run < 2; run++)
		begin
			apbWrite(ctrlAddr, 32'h1);
			// Halted flag drops as the run begins
			apbRead(ctrlAddr, rdata);
			checkValue("status while running", rdata, 32'h1);
			checkValue("halted output while running", {31'd0, halted}, 32'd0);
			waitForHalt();
			apbRead(ctrlAddr, rdata);
			checkValue("status after halt", rdata, 32'h2);
			checkValue("halted output", {31'd0, halted}, 32'd1);
			checkRegisters();
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/hazardIf.sv
hdl/controlUnit.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/instrMem.sv
hdl/apbDebugPort.sv
hdl/pipeCore.sv
hdl/mipsPipeTop.sv
sim/tbMipsPipe.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tbMipsPipe
FILELIST = filelist.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
